// File: Bender.yml
package:
  name: csb_window_engine

sources:
  - files:
      - design/csb_pkg.sv
      - design/cmd_loader.sv
      - design/csb_seq.sv
      - design/win_dispatch.sv
      - design/pool_lane.sv
      - design/result_collect.sv
      - design/csb_top.sv
  - target: test
    files:
      - dv/tb_csb.sv

// File: design/cmd_loader.sv
module cmd_loader
    import csb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        i_cmd_req,
    input  logic [31:0] i_cmd_word,
    output logic        o_cmd_ack,
    input  logic        i_fetch,     // Sequencer wants a command
    output logic        o_cmd_vld,
    output cmd_t        o_cmd
);

    logic [1:0] word_cnt;   // Words whose handshake has completed
    logic       cmd_full;   // All words in, vld pending
    logic       take_word;  // Accept the word on the port

    assign cmd_full  = (word_cnt == 2'(CMD_WORDS));
    // No new word while a command is waiting to be handed over
    assign take_word = i_cmd_req && !o_cmd_ack && i_fetch && !cmd_full && !o_cmd_vld;

    // Four-phase receiver and word counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_cmd_ack <= 1'b0;
            o_cmd_vld <= 1'b0;
            word_cnt  <= '0;
        end else begin
            o_cmd_vld <= 1'b0;                  // Single-cycle pulse
            if (take_word) begin
                o_cmd_ack <= 1'b1;              // One cycle after req seen
            end else if (o_cmd_ack && !i_cmd_req) begin
                o_cmd_ack <= 1'b0;              // Sender released req
                word_cnt  <= word_cnt + 2'd1;   // Word counts once ack falls
            end else if (cmd_full) begin
                o_cmd_vld <= 1'b1;              // Cycle after last ack fell
                word_cnt  <= '0;
            end
        end
    end

    // Split words into command fields
    always_ff @(posedge clk) begin
        if (take_word) begin
            case (word_cnt)
                2'd0: begin
                    o_cmd.op_type <= i_cmd_word[2:0];
                    o_cmd.last    <= i_cmd_word[7];
                    o_cmd.op_num  <= i_cmd_word[31:16];
                end
                2'd1:    o_cmd.weight   <= i_cmd_word;  // Four packed weights
                default: o_cmd.res_addr <= i_cmd_word;
            endcase
        end
    end

endmodule

// File: design/csb_pkg.sv
package csb_pkg;

    localparam int NUM_LANE  = 4;                 // Parallel compute lanes
    localparam int LANE_W    = $clog2(NUM_LANE);  // Round-robin pointer width
    localparam int CMD_WORDS = 3;                 // Words per command
    localparam int NUM_PIX   = 4;                 // Pixels in one 2x2 window
    localparam int VAL_W     = 16;                // Lane result width

    // Op codes kept from the full command set
    localparam logic [2:0] OP_CONV = 3'd1;        // 1x1 conv with ReLU
    localparam logic [2:0] OP_MAX  = 3'd4;        // 2x2 max pooling
    localparam logic [2:0] OP_AVG  = 3'd5;        // 2x2 average pooling

    typedef logic signed [7:0] wgt_t;             // One signed weight

    typedef struct packed {
        logic [2:0]         op_type;   // Word 0 bits 2:0
        logic               last;      // Word 0 bit 7
        logic [15:0]        op_num;    // Word 0 bits 31:16, window count
        wgt_t [NUM_PIX-1:0] weight;    // Word 1, weight k at bits 8k+7:8k
        logic [31:0]        res_addr;  // Word 2, first result address
    } cmd_t;

    typedef struct packed {
        logic [2:0]         op_type;
        wgt_t [NUM_PIX-1:0] weight;
    } job_t;

    typedef struct packed {
        logic [NUM_PIX-1:0][7:0] pix;  // Unsigned pixels, pix[0] in bits 7:0
    } win_t;

    typedef struct packed {
        logic [31:0]      addr;
        logic [VAL_W-1:0] val;
    } res_t;

endpackage

// File: design/csb_seq.sv
module csb_seq
    import csb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        i_op_en,
    input  logic        i_cmd_vld,
    input  cmd_t        i_cmd,
    output logic        o_fetch,
    output job_t        o_job,
    output logic        o_run,
    output logic [15:0] o_op_num,
    output logic [31:0] o_res_addr,
    input  logic        i_res_done,
    output logic        o_irq
);

    typedef enum logic [2:0] {
        idle      = 3'd0,
        cmd_get   = 3'd1,   // Wait for the loader
        cmd_issue = 3'd2,   // Decide whether there is work
        op_run    = 3'd3,   // Count drained results
        finish    = 3'd4
    } state_t;

    state_t      curr_state;
    state_t      next_state;
    cmd_t        cmd_q;       // Command being executed
    logic [15:0] done_cnt;    // Results drained so far
    logic        op_known;
    logic        op_empty;
    logic        last_done;

    assign op_known  = (cmd_q.op_type == OP_CONV) || (cmd_q.op_type == OP_MAX) ||
                       (cmd_q.op_type == OP_AVG);
    // Unknown ops and zero-length ops complete without windows
    assign op_empty  = !op_known || (cmd_q.op_num == 16'd0);
    assign last_done = i_res_done && ((done_cnt + 16'd1) == cmd_q.op_num);

    always_comb begin
        next_state = curr_state;
        case (curr_state)
            idle:      if (i_op_en) next_state = cmd_get;
            cmd_get:   if (i_cmd_vld) next_state = cmd_issue;
            cmd_issue: begin
                if (!op_empty) next_state = op_run;
                else           next_state = cmd_q.last ? finish : cmd_get;
            end
            op_run:    if (last_done) next_state = cmd_q.last ? finish : cmd_get;
            finish:    next_state = finish;  // Held until reset
            default:   next_state = idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            curr_state <= idle;
            done_cnt   <= '0;
            o_irq      <= 1'b0;
        end else begin
            curr_state <= next_state;
            if (curr_state == cmd_issue)
                done_cnt <= '0;
            else if (curr_state == op_run && i_res_done)
                done_cnt <= done_cnt + 16'd1;
            if (curr_state == finish)
                o_irq <= 1'b1;                  // Sticky
        end
    end

    always_ff @(posedge clk) begin
        if (curr_state == cmd_get && i_cmd_vld)
            cmd_q <= i_cmd;
    end

    assign o_fetch        = (curr_state == cmd_get);
    assign o_run          = (curr_state == op_run);   // Low outside an op
    assign o_job.op_type  = cmd_q.op_type;
    assign o_job.weight   = cmd_q.weight;
    assign o_op_num       = cmd_q.op_num;
    assign o_res_addr     = cmd_q.res_addr;

endmodule

// File: design/csb_top.sv
module csb_top
    import csb_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        i_op_en,
    input  logic        i_cmd_req,   // Command port
    input  logic [31:0] i_cmd_word,
    output logic        o_cmd_ack,
    input  logic        i_win_req,   // Window port
    input  win_t        i_win_data,
    output logic        o_win_ack,
    output logic        o_res_req,   // Result port
    output res_t        o_res,
    input  logic        i_res_ack,
    output logic        o_irq
);

    logic                           fetch;
    logic                           cmd_vld;
    cmd_t                           cmd;
    job_t                           job;
    logic                           run;
    logic [15:0]                    op_num;
    logic [31:0]                    res_addr;
    logic                           res_done;
    win_t                           win;
    logic [NUM_LANE-1:0]            lane_ld;
    logic [NUM_LANE-1:0]            lane_clr;
    logic [NUM_LANE-1:0]            lane_vld;   // Also the lane busy flags
    logic [NUM_LANE-1:0][VAL_W-1:0] lane_val;

    cmd_loader u_loader (
        .clk, .rst, .i_cmd_req, .i_cmd_word, .o_cmd_ack,
        .i_fetch(fetch), .o_cmd_vld(cmd_vld), .o_cmd(cmd)
    );

    csb_seq u_seq (
        .clk, .rst, .i_op_en, .i_cmd_vld(cmd_vld), .i_cmd(cmd), .o_fetch(fetch),
        .o_job(job), .o_run(run), .o_op_num(op_num), .o_res_addr(res_addr),
        .i_res_done(res_done), .o_irq
    );

    win_dispatch u_dispatch (
        .clk, .rst, .i_win_req, .i_win_data, .o_win_ack, .i_run(run), .i_op_num(op_num),
        .i_lane_busy(lane_vld), .o_lane_ld(lane_ld), .o_win(win)
    );

    for (genvar k = 0; k < NUM_LANE; k++) begin : g_lane
        pool_lane u_lane (
            .clk, .rst, .i_ld(lane_ld[k]), .i_win(win), .i_job(job),
            .i_clr(lane_clr[k]), .o_vld(lane_vld[k]), .o_val(lane_val[k])
        );
    end

    result_collect u_collect (
        .clk, .rst, .i_run(run), .i_res_addr(res_addr), .i_lane_vld(lane_vld),
        .i_lane_val(lane_val), .o_lane_clr(lane_clr), .o_res_req, .o_res,
        .i_res_ack, .o_res_done(res_done)
    );

endmodule

// File: design/pool_lane.sv
module pool_lane
    import csb_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             i_ld,
    input  win_t             i_win,
    input  job_t             i_job,
    input  logic             i_clr,
    output logic             o_vld,
    output logic [VAL_W-1:0] o_val
);

    logic signed [17:0] conv_sum;  // Wide enough for four 9x8 products
    logic [9:0]         pix_sum;
    logic [7:0]         pix_max;
    logic [VAL_W-1:0]   val_nxt;

    always_comb begin
        conv_sum = '0;
        pix_sum  = '0;
        pix_max  = i_win.pix[0];
        for (int k = 0; k < NUM_PIX; k++) begin
            conv_sum = conv_sum + $signed({1'b0, i_win.pix[k]}) * $signed(i_job.weight[k]);
            pix_sum  = pix_sum + 10'(i_win.pix[k]);
            if (i_win.pix[k] > pix_max) pix_max = i_win.pix[k];
        end
        case (i_job.op_type)
            OP_CONV: begin
                if (conv_sum < 0)                 val_nxt = '0;         // ReLU
                else if (conv_sum > 18'sd65535)   val_nxt = '1;         // Clamp to 16 bits
                else                              val_nxt = conv_sum[15:0];
            end
            OP_MAX:  val_nxt = {8'd0, pix_max};
            OP_AVG:  val_nxt = {8'd0, pix_sum[9:2]};  // Divide by four
            default: val_nxt = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)         o_vld <= 1'b0;
        else if (i_ld)   o_vld <= 1'b1;   // Result ready next cycle
        else if (i_clr)  o_vld <= 1'b0;   // Collector has taken it
    end

    always_ff @(posedge clk) begin
        if (i_ld) o_val <= val_nxt;
    end

endmodule

// File: design/result_collect.sv
module result_collect
    import csb_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_run,
    input  logic [31:0]                    i_res_addr,
    input  logic [NUM_LANE-1:0]            i_lane_vld,
    input  logic [NUM_LANE-1:0][VAL_W-1:0] i_lane_val,
    output logic [NUM_LANE-1:0]            o_lane_clr,
    output logic                           o_res_req,
    output res_t                           o_res,
    input  logic                           i_res_ack,
    output logic                           o_res_done
);

    typedef enum logic [1:0] {
        ph_idle,    // Waiting on the pointed lane
        ph_req,     // req high, waiting for ack
        ph_rel      // req dropped, waiting for ack to fall
    } phase_t;

    phase_t            phase;
    logic [LANE_W-1:0] rd_ptr;    // Same order as the dispatcher
    logic [31:0]       addr_cnt;
    logic              run_q;     // For run edge detect
    logic              send;

    assign send = (phase == ph_idle) && i_lane_vld[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase      <= ph_idle;
            rd_ptr     <= '0;
            addr_cnt   <= '0;
            run_q      <= 1'b0;
            o_res_req  <= 1'b0;
            o_lane_clr <= '0;
            o_res_done <= 1'b0;
        end else begin
            run_q      <= i_run;
            o_lane_clr <= '0;
            o_res_done <= 1'b0;
            if (i_run && !run_q)
                addr_cnt <= i_res_addr;         // New op, new base address
            case (phase)
                ph_idle: if (send) begin
                    o_res_req <= 1'b1;
                    phase     <= ph_req;
                end
                ph_req: if (i_res_ack) begin
                    o_res_req          <= 1'b0;
                    o_lane_clr[rd_ptr] <= 1'b1; // Free the lane
                    rd_ptr   <= (rd_ptr == LANE_W'(NUM_LANE - 1)) ? '0 : rd_ptr + 1'b1;
                    addr_cnt <= addr_cnt + 32'd1;
                    phase    <= ph_rel;
                end
                ph_rel: if (!i_res_ack) begin
                    o_res_done <= 1'b1;         // Handshake closed
                    phase      <= ph_idle;
                end
                default: phase <= ph_idle;
            endcase
            if (!i_run)
                rd_ptr <= '0;
        end
    end

    // Result held stable while req is high
    always_ff @(posedge clk) begin
        if (send) begin
            o_res.addr <= addr_cnt;
            o_res.val  <= i_lane_val[rd_ptr];
        end
    end

endmodule

// File: design/win_dispatch.sv
module win_dispatch
    import csb_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                i_win_req,
    input  win_t                i_win_data,
    output logic                o_win_ack,
    input  logic                i_run,
    input  logic [15:0]         i_op_num,
    input  logic [NUM_LANE-1:0] i_lane_busy,
    output logic [NUM_LANE-1:0] o_lane_ld,
    output win_t                o_win
);

    logic [15:0]         win_cnt;   // Windows taken in this op
    logic [LANE_W-1:0]   rr_ptr;    // Next lane to load
    logic [NUM_LANE-1:0] busy;
    logic                take_win;

    assign busy     = i_lane_busy | o_lane_ld;  // Lane being loaded counts as full
    assign take_win = i_win_req && !o_win_ack && i_run && (win_cnt < i_op_num) &&
                      !busy[rr_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_win_ack <= 1'b0;
            o_lane_ld <= '0;
            win_cnt   <= '0;
            rr_ptr    <= '0;
        end else begin
            o_lane_ld <= '0;
            if (take_win) begin
                o_win_ack         <= 1'b1;
                o_lane_ld[rr_ptr] <= 1'b1;      // Same cycle as ack rise
                win_cnt           <= win_cnt + 16'd1;
                rr_ptr            <= (rr_ptr == LANE_W'(NUM_LANE - 1)) ? '0 : rr_ptr + 1'b1;
            end else if (o_win_ack && !i_win_req) begin
                o_win_ack <= 1'b0;
            end
            if (!i_run) begin
                win_cnt <= '0;                  // Fresh count per op
                rr_ptr  <= '0;                  // Collector restarts at lane 0 too
            end
        end
    end

    // Shared window bus to all lanes
    always_ff @(posedge clk) begin
        if (take_win)
            o_win <= i_win_data;
    end

endmodule

// File: dv/tb_csb.sv
module tb_csb
    import csb_pkg::*;
();

    localparam int CONV_N     = 24;
    localparam int POOL_N     = 20;
    localparam int ADDR_N0    = 6;
    localparam int ADDR_N1    = 5;
    localparam int BP_N       = 12;
    localparam int LAST_N     = 6;
    localparam int TOTAL_WIN  = CONV_N + 2 * POOL_N + ADDR_N0 + ADDR_N1 + BP_N + LAST_N;
    localparam int MAX_CYCLES = 40 * TOTAL_WIN + 2000;  // Run limit

    logic        clk;
    logic        rst;
    logic        i_op_en;
    logic        i_cmd_req;
    logic [31:0] i_cmd_word;
    logic        o_cmd_ack;
    logic        i_win_req;
    win_t        i_win_data;
    logic        o_win_ack;
    logic        o_res_req;
    res_t        o_res;
    logic        i_res_ack;
    logic        o_irq;

    res_t        exp_q[$];         // Expected results, window order
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_err0;        // Error count when the test began
    int          sent_cnt;
    int          got_cnt;
    int          neg_cnt;          // Conv windows with a negative sum
    int          cycles;
    int          stall_cycles;     // One-shot ack hold for back-pressure
    logic        final_queued;     // Command with last flag is on its way
    logic        full_stall_seen;
    logic        p_cmd_req;        // Previous-cycle copies for the protocol checks
    logic        p_cmd_ack;
    logic        p_win_req;
    logic        p_win_ack;
    logic        p_res_req;
    logic        p_res_ack;
    logic        p_full;
    logic        p_irq;
    logic [47:0] p_cmd_data;
    logic [47:0] p_win_data;
    logic [47:0] p_res_data;

    csb_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // Signed dot product of pixels and weights
    function automatic int conv_sum(input logic [31:0] wts, input win_t w);
        int s;
        s = 0;
        for (int k = 0; k < NUM_PIX; k++)
            s += int'(w.pix[k]) * int'($signed(wts[8*k +: 8]));
        return s;
    endfunction

    function automatic logic [15:0] model_val(input logic [2:0] op, input logic [31:0] wts,
                                              input win_t w);
        int s;
        int m;
        s = 0;
        m = 0;
        for (int k = 0; k < NUM_PIX; k++) begin
            s += int'(w.pix[k]);
            if (int'(w.pix[k]) > m) m = int'(w.pix[k]);
        end
        case (op)
            OP_CONV: begin
                s = conv_sum(wts, w);
                if (s < 0) s = 0;            // ReLU
                if (s > 65535) s = 65535;    // Saturate at 16 bits
                return 16'(s);
            end
            OP_MAX:  return 16'(m);
            OP_AVG:  return 16'(s >> 2);
            default: return 16'd0;
        endcase
    endfunction

    task automatic note_error(input string what);
        $display("%0t: %s", $time, what);
        errors++;
    endtask

    task automatic val_error(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, got);
        errors++;
    endtask

    // Four-phase order and data hold on one port
    task automatic check_port(input string port, input logic req, p_req, ack, p_ack,
                              input logic [47:0] data, p_data);
        assert (!(ack && !p_ack) || req)
            else note_error($sformatf("%s port: ack rose with req low", port));
        assert (!(!ack && p_ack) || !req)
            else note_error($sformatf("%s port: ack fell while req still high", port));
        assert (!(req && !p_req) || !ack)
            else note_error($sformatf("%s port: req rose before ack fell", port));
        assert (!(!req && p_req) || ack)
            else note_error($sformatf("%s port: req dropped before ack", port));
        assert (!(req && p_req) || data == p_data)
            else note_error($sformatf("%s port: data changed while req high", port));
    endtask

    task automatic send_cmd_word(input logic [31:0] word);
        repeat ($urandom_range(0, 2)) @(posedge clk);  // Random gap
        i_cmd_word <= word;
        i_cmd_req  <= 1'b1;
        do @(posedge clk); while (!o_cmd_ack);
        i_cmd_req <= 1'b0;
        do @(posedge clk); while (o_cmd_ack);
    endtask

    task automatic send_window(input win_t w);
        repeat ($urandom_range(0, 2)) @(posedge clk);
        i_win_data <= w;
        i_win_req  <= 1'b1;
        do @(posedge clk); while (!o_win_ack);
        i_win_req <= 1'b0;
        do @(posedge clk); while (o_win_ack);
    endtask

    // Queue the model result, then offer the window
    task automatic send_windows(input logic [2:0] op, input int n, input logic [31:0] wts,
                                input logic [31:0] addr);
        win_t w;
        res_t e;
        if (op == OP_CONV || op == OP_MAX || op == OP_AVG) begin  // Other ops take none
            for (int i = 0; i < n; i++) begin
                w      = win_t'($urandom);
                e.addr = addr + 32'(i);
                e.val  = model_val(op, wts, w);
                if (op == OP_CONV && conv_sum(wts, w) < 0) neg_cnt++;
                exp_q.push_back(e);
                sent_cnt++;
                send_window(w);
            end
        end
    endtask

    task automatic run_cmd(input logic [2:0] op, input logic last, input int n,
                           input logic [31:0] wts, input logic [31:0] addr);
        logic [31:0] words [CMD_WORDS];
        words[0] = {n[15:0], 8'd0, last, 4'd0, op};
        words[1] = wts;
        words[2] = addr;
        fork
            for (int k = 0; k < CMD_WORDS; k++) send_cmd_word(words[k]);
            send_windows(op, n, wts, addr);
        join
    endtask

    task automatic wait_drained();
        do @(posedge clk); while (exp_q.size() != 0 || o_res_req || i_res_ack);
        repeat (4) @(posedge clk);
        assert (got_cnt == sent_cnt)
            else note_error($sformatf("%0d results received for %0d windows", got_cnt, sent_cnt));
    endtask

    task automatic begin_test();
        test_err0 = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_err0) begin
            $display("Test %-12s done, no errors", name);
        end else begin
            tests_failed++;
            $display("Test %-12s done, %0d errors", name, errors - test_err0);
        end
    endtask

    // Result receiver with random ack delay
    always begin : result_agent
        int   hold;
        res_t e;
        @(posedge clk);
        if (!rst && o_res_req && !i_res_ack) begin
            hold = (stall_cycles > 0) ? stall_cycles : int'($urandom_range(0, 3));
            stall_cycles = 0;
            repeat (hold) @(posedge clk);
            assert (exp_q.size() != 0)
                else note_error($sformatf("result for %0h arrived with none expected", o_res.addr));
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                assert (o_res.addr == e.addr) else val_error("o_res.addr", e.addr, o_res.addr);
                assert (o_res.val == e.val) else val_error("o_res.val", 32'(e.val), 32'(o_res.val));
            end
            got_cnt++;
            i_res_ack <= 1'b1;
            do @(posedge clk); while (o_res_req);
            i_res_ack <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            check_port("command", i_cmd_req, p_cmd_req, o_cmd_ack, p_cmd_ack,
                       {16'd0, i_cmd_word}, p_cmd_data);
            check_port("window", i_win_req, p_win_req, o_win_ack, p_win_ack,
                       {16'd0, i_win_data}, p_win_data);
            check_port("result", o_res_req, p_res_req, i_res_ack, p_res_ack, o_res, p_res_data);
            assert (!(p_full && !p_win_ack) || !o_win_ack)
                else note_error("window ack rose while every lane held a result");
            if (&dut0.lane_vld && i_win_req && !o_win_ack)
                full_stall_seen = 1'b1;   // All lanes full, window waiting
            // Last handshake closed on the result port before irq
            assert (p_irq || !o_irq || (final_queued && exp_q.size() == 0 &&
                                        got_cnt == sent_cnt && !o_res_req && !i_res_ack))
                else note_error("o_irq rose before the last result was acknowledged");
            assert (!p_irq || o_irq) else note_error("o_irq fell after it was raised");
        end
        p_cmd_req  = i_cmd_req;
        p_cmd_ack  = o_cmd_ack;
        p_cmd_data = {16'd0, i_cmd_word};
        p_win_req  = i_win_req;
        p_win_ack  = o_win_ack;
        p_win_data = {16'd0, i_win_data};
        p_res_req  = o_res_req;
        p_res_ack  = i_res_ack;
        p_res_data = o_res;
        p_full     = &dut0.lane_vld;
        p_irq      = o_irq;
    end

    initial begin : main_seq
        int          seed_ret;
        logic [31:0] conv_wts;
        seed_ret        = $urandom(14575);
        rst             = 1'b1;
        i_op_en         = 1'b0;
        i_cmd_req       = 1'b0;
        i_cmd_word      = '0;
        i_win_req       = 1'b0;
        i_win_data      = '0;
        i_res_ack       = 1'b0;
        final_queued    = 1'b0;
        full_stall_seen = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        begin_test();
        // First conv word offered early, must not be taken while idle
        i_cmd_word <= {16'(CONV_N), 8'd0, 1'b0, 4'd0, OP_CONV};
        i_cmd_req  <= 1'b1;
        repeat (10) begin
            @(posedge clk);
            assert (!o_cmd_ack && !o_win_ack && !o_res_req && !o_irq)
                else note_error("an output went high before i_op_en");
        end
        end_test("reset");
        i_op_en <= 1'b1;

        begin_test();
        conv_wts = ($urandom | 32'h0000_0080) & 32'h7fff_ffff;  // w0 negative, w3 positive
        run_cmd(OP_CONV, 1'b0, CONV_N, conv_wts, 32'h0000_1000);
        wait_drained();
        assert (neg_cnt > 0) else note_error("no conv window had a negative sum");
        end_test("conv_relu");

        begin_test();
        run_cmd(OP_MAX, 1'b0, POOL_N, 32'h0, 32'h0000_2000);
        run_cmd(OP_AVG, 1'b0, POOL_N, 32'h0, 32'h0000_3000);
        wait_drained();
        end_test("pooling");

        begin_test();
        run_cmd(OP_CONV, 1'b0, ADDR_N0, $urandom, 32'h0000_fffd);  // Crosses bit 16
        run_cmd(OP_MAX, 1'b0, ADDR_N1, 32'h0, 32'h0000_0040);      // Base restarts lower
        wait_drained();
        end_test("addresses");

        begin_test();
        stall_cycles    = 80;
        full_stall_seen = 1'b0;
        run_cmd(OP_MAX, 1'b0, BP_N, 32'h0, 32'h0000_4000);
        wait_drained();
        assert (full_stall_seen) else note_error("held ack never filled all lanes");
        end_test("backpressure");

        begin_test();
        run_cmd(OP_CONV, 1'b0, 0, $urandom, 32'h0000_5000);  // op_num zero
        run_cmd(3'd2, 1'b0, 5, 32'h0, 32'h0000_6000);        // Unknown op, no windows
        repeat (20) @(posedge clk);
        assert (!o_irq) else note_error("o_irq rose before the last command");
        final_queued = 1'b1;
        run_cmd(OP_AVG, 1'b1, LAST_N, 32'h0, 32'h0000_7000);
        do @(posedge clk); while (!o_irq);
        wait_drained();
        repeat (10) @(posedge clk);                          // irq must hold
        end_test("irq_zero_op");

        $display("Tests run %0d, failed %0d, errors %0d, results %0d of %0d",
                 tests_run, tests_failed, errors, got_cnt, sent_cnt);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: files.f
design/csb_pkg.sv
design/cmd_loader.sv
design/csb_seq.sv
design/win_dispatch.sv
design/pool_lane.sv
design/result_collect.sv
design/csb_top.sv
dv/tb_csb.sv
